// File: rtl/vec_macros.svh
`ifndef VEC_MACROS_SVH
`define VEC_MACROS_SVH

// Width of one vector register in bits
`define VEC_VLEN 64

// Same width counted in bytes, one write enable per byte
`define VEC_VLENB 8

// Architectural vector registers v0 to v31
`define VEC_NREGS 32

// Host command word, decoded through vec_pkg::vec_cmd_u
`define VEC_CMD_W 24

`endif

// File: rtl/vec_pkg.sv
package vec_pkg;

    // Elementwise integer operations of the slice
    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,  // vs2 - op1
        OP_RSUB = 3'd2,  // op1 - vs2
        OP_AND  = 3'd3,
        OP_OR   = 3'd4,
        OP_XOR  = 3'd5,
        OP_MINU = 3'd6,
        OP_MAXU = 3'd7
    } vec_op_e;

    // One command word seen in two ways, selected by fmt (0 = vv, 1 = vi)
    // sew codes 0/1/2 give 8/16/32 bit elements, lmul codes 0..3 give 1/2/4/8 registers
    typedef union packed {
        struct packed {
            vec_op_e     op;
            logic        vm;     // Set means unmasked
            logic        fmt;
            logic [1:0]  sew;
            logic [1:0]  lmul;
            logic [4:0]  vd;
            logic [4:0]  vs2;
            logic [4:0]  vs1;
        } vv;
        struct packed {
            vec_op_e            op;
            logic               vm;
            logic               fmt;
            logic [1:0]         sew;
            logic [1:0]         lmul;
            logic [4:0]         vd;
            logic [4:0]         vs2;
            logic signed [4:0]  simm5;  // Sign-extended to the element width
        } vi;
    } vec_cmd_u;

endpackage

// File: rtl/vec_rf_if.sv
`timescale 1ns/10ps
`include "vec_macros.svh"

interface vec_rf_if;

    // Read addresses, driven by the issue FSM
    logic [4:0]              vs1_addr;
    logic [4:0]              vs2_addr;
    logic [4:0]              rd_addr;    // Old destination contents, or host readback when idle

    // Read data, driven by the bank
    logic [`VEC_VLEN-1:0]    vs1_data;
    logic [`VEC_VLEN-1:0]    vs2_data;
    logic [`VEC_VLEN-1:0]    rd_data;
    logic [`VEC_VLEN-1:0]    v0_mask;

    // Single write port, a zero wr_be means no write
    logic [4:0]              wr_addr;
    logic [`VEC_VLENB-1:0]   wr_be;
    logic [`VEC_VLEN-1:0]    wr_data;

    modport bank (
        input  vs1_addr, vs2_addr, rd_addr,
        input  wr_addr, wr_be, wr_data,
        output vs1_data, vs2_data, rd_data, v0_mask
    );

    modport ctrl (
        output vs1_addr, vs2_addr, rd_addr,
        output wr_addr, wr_be, wr_data
    );

    modport alu (
        input  vs1_data, vs2_data, rd_data, v0_mask
    );

endinterface

// File: rtl/vec_regbank.sv
`timescale 1ns/10ps
`include "vec_macros.svh"

module vec_regbank (
    input  logic      clk,
    input  logic      reset_n,
    vec_rf_if.bank    rf
);

    logic [`VEC_NREGS-1:0][`VEC_VLEN-1:0] regs;

    // All read ports are combinational
    assign rf.vs1_data = regs[rf.vs1_addr];
    assign rf.vs2_data = regs[rf.vs2_addr];
    assign rf.rd_data  = regs[rf.rd_addr];

    // Register 0 doubles as the element mask
    assign rf.v0_mask  = regs[0];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            regs <= '0;
        end
        else begin
            // Only bytes with their enable set are touched, the rest keep old data
            for (int i = 0; i < `VEC_VLENB; i++) begin
                if (rf.wr_be[i]) begin
                    regs[rf.wr_addr][8*i +: 8] <= rf.wr_data[8*i +: 8];
                end
            end
        end
    end

    // An unknown enable would corrupt bytes without a traceable write
    a_wr_be_known: assert property (
        @(posedge clk) disable iff (!reset_n) !$isunknown(rf.wr_be)
    ) else $error("vec_regbank: write byte enables are unknown");

endmodule

// File: rtl/vec_lane_alu.sv
`timescale 1ns/10ps
`include "vec_macros.svh"

module vec_lane_alu (
    input  logic                    clk,
    input  logic                    reset_n,
    vec_rf_if.alu                   rf,
    input  vec_pkg::vec_cmd_u       cmd,
    input  logic [2:0]              grp_idx,     // Register index inside the group
    input  logic                    issue,
    output logic [`VEC_VLEN-1:0]    res_data,
    output logic [`VEC_VLENB-1:0]   res_be,
    output logic                    res_valid
);

    localparam int VLEN  = `VEC_VLEN;
    localparam int VLENB = `VEC_VLENB;

    logic [5:0]        ew;        // Element width in bits
    logic [3:0]        nelem;     // Elements per register
    logic [31:0]       wmask;
    logic [31:0]       imm;
    logic [31:0]       opa;
    logic [31:0]       opb;
    logic [31:0]       ores;
    logic [VLEN-1:0]   el_res;
    logic [VLENB-1:0]  el_en;
    logic [VLEN-1:0]   nxt_data;
    logic [VLENB-1:0]  nxt_be;

    // Operands are zero-extended, so the unsigned compares need no width case
    function automatic logic [31:0] elem_op(
        input vec_pkg::vec_op_e op,
        input logic [31:0]      a,
        input logic [31:0]      b
    );
        case (op)
            vec_pkg::OP_ADD:  return a + b;
            vec_pkg::OP_SUB:  return a - b;
            vec_pkg::OP_RSUB: return b - a;
            vec_pkg::OP_AND:  return a & b;
            vec_pkg::OP_OR:   return a | b;
            vec_pkg::OP_XOR:  return a ^ b;
            vec_pkg::OP_MINU: return (a < b) ? a : b;
            vec_pkg::OP_MAXU: return (a > b) ? a : b;
            default:          return a;
        endcase
    endfunction

    assign ew    = 6'(8 << cmd.vv.sew);
    assign nelem = 4'(VLENB >> cmd.vv.sew);
    assign wmask = (ew == 6'd32) ? 32'hffff_ffff : ((32'd1 << ew) - 32'd1);
    assign imm   = {{27{cmd.vi.simm5[4]}}, cmd.vi.simm5};

    always_comb begin
        el_res = '0;
        el_en  = '0;
        opa    = '0;
        opb    = '0;
        ores   = '0;
        for (int j = 0; j < VLENB; j++) begin
            if (j < int'(nelem)) begin
                opa    = 32'(rf.vs2_data >> (j * ew)) & wmask;
                opb    = cmd.vv.fmt ? (imm & wmask) : (32'(rf.vs1_data >> (j * ew)) & wmask);
                ores   = elem_op(cmd.vv.op, opa, opb) & wmask;  // Wraps at the element width
                el_res = el_res | (VLEN'(ores) << (j * ew));
                // Mask bits run on across the registers of a group
                el_en[j] = cmd.vv.vm | rf.v0_mask[int'(grp_idx) * int'(nelem) + j];
            end
        end

        // Each byte follows the enable of the element it belongs to
        for (int i = 0; i < VLENB; i++) begin
            nxt_be[i]          = el_en[i >> cmd.vv.sew];
            nxt_data[8*i +: 8] = nxt_be[i] ? el_res[8*i +: 8] : rf.rd_data[8*i +: 8];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            res_valid <= 1'b0;
            res_be    <= '0;
        end
        else begin
            res_valid <= issue;
            if (issue) begin
                res_be <= nxt_be;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            res_data <= nxt_data;
        end
    end

endmodule

// File: rtl/vec_group_counter.sv
`timescale 1ns/10ps

module vec_group_counter (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        start,
    input  logic [1:0]  lmul,     // Group size is 1 << lmul
    output logic [2:0]  count,
    output logic        last,
    output logic        running
);

    logic [2:0] last_idx;

    assign last_idx = 3'((4'd1 << lmul) - 4'd1);
    assign last     = running && (count == last_idx);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            count   <= '0;
            running <= 1'b0;
        end
        else if (start) begin
            count   <= '0;
            running <= 1'b1;
        end
        else if (running) begin
            if (last) begin
                running <= 1'b0;  // Count holds at the last index
            end
            else begin
                count <= count + 3'd1;
            end
        end
    end

    // lmul comes from the latched command and must not change mid-group
    a_count_in_group: assert property (
        @(posedge clk) disable iff (!reset_n) running |-> (count <= last_idx)
    ) else $error("vec_group_counter: count %0d beyond group end %0d", count, last_idx);

endmodule

// File: rtl/vec_issue_fsm.sv
`timescale 1ns/10ps
`include "vec_macros.svh"

module vec_issue_fsm (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    cmd_valid,
    input  logic [`VEC_CMD_W-1:0]   cmd_word,
    input  logic                    ld_en,
    input  logic [4:0]              ld_addr,
    input  logic [`VEC_VLEN-1:0]    ld_data,
    input  logic [4:0]              rd_addr_in,
    vec_rf_if.ctrl                  rf,
    input  logic [`VEC_VLEN-1:0]    res_data,
    input  logic [`VEC_VLENB-1:0]   res_be,
    input  logic                    res_valid,
    output logic                    cnt_start,
    input  logic                    cnt_last,
    input  logic [2:0]              count,
    output logic                    issue,
    output vec_pkg::vec_cmd_u       cmd,
    output logic                    busy,
    output logic                    done,
    output logic                    err
);

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_RUN    = 2'd1;
    localparam logic [1:0] ST_DRAIN  = 2'd2;  // Last result still in the ALU register
    localparam logic [1:0] ST_FINISH = 2'd3;

    logic [1:0]         state;
    logic [2:0]         cnt_d;      // Group index of the result now leaving the ALU
    vec_pkg::vec_cmd_u  cmd_in;
    logic [4:0]         align_mask;
    logic               aligned;
    logic               legal;

    // Legality is checked on the raw word before anything is latched
    assign cmd_in     = cmd_word;
    assign align_mask = 5'((4'd1 << cmd_in.vv.lmul) - 4'd1);
    assign aligned    = ((cmd_in.vv.vd & align_mask) == 5'd0) &&
                        ((cmd_in.vv.vs2 & align_mask) == 5'd0) &&
                        (cmd_in.vv.fmt || ((cmd_in.vv.vs1 & align_mask) == 5'd0));
    assign legal      = aligned && (cmd_in.vv.sew != 2'd3);
    assign cnt_start  = (state == ST_IDLE) && cmd_valid && legal;

    assign issue = (state == ST_RUN);
    assign busy  = (state != ST_IDLE);
    assign done  = (state == ST_FINISH);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= ST_IDLE;
            cmd   <= '0;
            cnt_d <= '0;
            err   <= 1'b0;
        end
        else begin
            cnt_d <= count;
            err   <= (state == ST_IDLE) && cmd_valid && !legal;  // Rejected commands leave busy low
            case (state)
                ST_IDLE: begin
                    if (cnt_start) begin
                        cmd   <= cmd_in;
                        state <= ST_RUN;
                    end
                end
                ST_RUN: begin
                    if (cnt_last) begin
                        state <= ST_DRAIN;
                    end
                end
                ST_DRAIN:  state <= ST_FINISH;
                default:   state <= ST_IDLE;
            endcase
        end
    end

    // Group register k of every operand is read in run cycle k
    assign rf.vs1_addr = 5'(cmd.vv.vs1 + {2'b00, count});
    assign rf.vs2_addr = 5'(cmd.vv.vs2 + {2'b00, count});
    assign rf.rd_addr  = (state == ST_RUN) ? 5'(cmd.vv.vd + {2'b00, count}) : rd_addr_in;

    always_comb begin
        rf.wr_addr = ld_addr;
        rf.wr_be   = '0;
        rf.wr_data = ld_data;
        if (state == ST_IDLE) begin
            if (ld_en) begin
                rf.wr_be = '1;  // Host loads replace the whole register
            end
        end
        else if (res_valid) begin
            rf.wr_addr = 5'(cmd.vv.vd + {2'b00, cnt_d});
            rf.wr_be   = res_be;
            rf.wr_data = res_data;
        end
    end

    // err only follows an idle cycle, done only ends a sequence
    a_done_err_exclusive: assert property (
        @(posedge clk) disable iff (!reset_n) !(done && err)
    ) else $error("vec_issue_fsm: done and err raised together");

endmodule

// File: rtl/vec_unit.sv
`timescale 1ns/10ps
`include "vec_macros.svh"

module vec_unit (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    cmd_valid,
    input  logic [`VEC_CMD_W-1:0]   cmd_word,
    input  logic                    ld_en,
    input  logic [4:0]              ld_addr,
    input  logic [`VEC_VLEN-1:0]    ld_data,
    input  logic [4:0]              rd_addr_in,
    output logic [`VEC_VLEN-1:0]    rd_data_out,
    output logic                    busy,
    output logic                    done,
    output logic                    err
);

    vec_rf_if rf ();

    vec_pkg::vec_cmd_u          cmd;
    logic [`VEC_VLEN-1:0]       res_data;
    logic [`VEC_VLENB-1:0]      res_be;
    logic                       res_valid;
    logic                       cnt_start;
    logic                       cnt_last;
    logic [2:0]                 count;
    logic                       issue;

    // Host readback shares the destination read port while idle
    assign rd_data_out = rf.rd_data;

    vec_regbank u_regbank (
        .clk        (clk),
        .reset_n    (reset_n),
        .rf         (rf)
    );

    vec_lane_alu u_alu (
        .clk        (clk),
        .reset_n    (reset_n),
        .rf         (rf),
        .cmd        (cmd),
        .grp_idx    (count),
        .issue      (issue),
        .res_data   (res_data),
        .res_be     (res_be),
        .res_valid  (res_valid)
    );

    vec_group_counter u_counter (
        .clk        (clk),
        .reset_n    (reset_n),
        .start      (cnt_start),
        .lmul       (cmd.vv.lmul),
        .count      (count),
        .last       (cnt_last),
        .running    ()
    );

    vec_issue_fsm u_fsm (
        .clk        (clk),
        .reset_n    (reset_n),
        .cmd_valid  (cmd_valid),
        .cmd_word   (cmd_word),
        .ld_en      (ld_en),
        .ld_addr    (ld_addr),
        .ld_data    (ld_data),
        .rd_addr_in (rd_addr_in),
        .rf         (rf),
        .res_data   (res_data),
        .res_be     (res_be),
        .res_valid  (res_valid),
        .cnt_start  (cnt_start),
        .cnt_last   (cnt_last),
        .count      (count),
        .issue      (issue),
        .cmd        (cmd),
        .busy       (busy),
        .done       (done),
        .err        (err)
    );

endmodule

// File: test/tb_vec_unit.sv
`timescale 1ns/10ps
`include "vec_macros.svh"

module tb_vec_unit;

    localparam int SWEEP_CYCLES  = 32;                   // One readback per register
    localparam int LOAD_CYCLES   = 2 * 33;               // 32 initial loads and one v0 reload
    localparam int EXEC_CYCLES   = 22 + SWEEP_CYCLES;    // Issue, wait for done, readback
    localparam int REJECT_CYCLES = 2 + SWEEP_CYCLES;
    localparam int NUM_EXEC      = 46;  // 24 vv, 9 vi, 6 masked, 6 grouped, 1 with dropped traffic
    localparam int NUM_REJECT    = 3;
    localparam int TEST_CYCLES   = 17 + LOAD_CYCLES + 2 * SWEEP_CYCLES
                                   + NUM_EXEC * EXEC_CYCLES + NUM_REJECT * REJECT_CYCLES;

    logic                   clk;
    logic                   reset_n;
    logic                   cmd_valid;
    logic [`VEC_CMD_W-1:0]  cmd_word;
    logic                   ld_en;
    logic [4:0]             ld_addr;
    logic [`VEC_VLEN-1:0]   ld_data;
    logic [4:0]             rd_addr_in;
    logic [`VEC_VLEN-1:0]   rd_data_out;
    logic                   busy;
    logic                   done;
    logic                   err;

    logic [`VEC_VLEN-1:0]   shadow [32];
    int                     seed = 32'h0f43_de46;
    int                     errors = 0;
    int                     tests = 0;
    int                     test_start_errors;

    vec_unit dut (
        .clk(clk), .reset_n(reset_n), .cmd_valid(cmd_valid), .cmd_word(cmd_word),
        .ld_en(ld_en), .ld_addr(ld_addr), .ld_data(ld_data), .rd_addr_in(rd_addr_in),
        .rd_data_out(rd_data_out), .busy(busy), .done(done), .err(err)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(TEST_CYCLES * 8 + 2000);
        $display("Watchdog expired before the tests completed");
        $display("CHECKS FAILED");
        $finish;
    end

    // Reference for one element, a is the vs2 element and b the vs1 element or immediate
    function automatic logic [31:0] ref_elem(input logic [2:0] op, input logic [31:0] a,
                                             input logic [31:0] b);
        case (op)
            3'd0: return a + b;
            3'd1: return a - b;
            3'd2: return b - a;
            3'd3: return a & b;
            3'd4: return a | b;
            3'd5: return a ^ b;
            3'd6: return (a < b) ? a : b;
            default: return (a > b) ? a : b;
        endcase
    endfunction

    task automatic update_model(input logic [2:0] op, input logic vm, input logic fmt,
                                input logic [1:0] sew, input logic [1:0] lmul,
                                input logic [4:0] vd, input logic [4:0] vs2,
                                input logic [4:0] last);
        logic [`VEC_VLEN-1:0] old [32];
        int w;
        int ne;
        int n;
        logic [31:0] msk;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        old = shadow;
        w   = 8 << sew;
        ne  = 64 / w;
        n   = 1 << lmul;
        msk = (w == 32) ? 32'hffff_ffff : ((32'h1 << w) - 32'h1);
        for (int k = 0; k < n; k++) begin
            for (int j = 0; j < ne; j++) begin
                a = 32'(old[int'(vs2) + k] >> (j * w)) & msk;
                b = fmt ? ({{27{last[4]}}, last} & msk)
                        : (32'(old[int'(last) + k] >> (j * w)) & msk);
                r = ref_elem(op, a, b) & msk;
                if (vm || old[0][k * ne + j]) begin
                    shadow[int'(vd) + k] = (shadow[int'(vd) + k] & ~(64'(msk) << (j * w)))
                                           | (64'(r) << (j * w));
                end
            end
        end
    endtask

    task automatic load_reg(input logic [4:0] addr, input logic [`VEC_VLEN-1:0] data);
        @(negedge clk);
        ld_en   = 1'b1;
        ld_addr = addr;
        ld_data = data;
        @(negedge clk);
        ld_en = 1'b0;
        shadow[addr] = data;
    endtask

    task automatic check_all_regs(input string name);
        for (int r = 0; r < 32; r++) begin
            @(negedge clk);
            rd_addr_in = 5'(r);
            #2;
            if (rd_data_out !== shadow[r]) begin
                $display("ERROR %s v%0d: expected %h, actual %h", name, r, shadow[r],
                         rd_data_out);
                errors++;
            end
        end
    endtask

    // Drives one legal command, optionally with host traffic while busy, and checks it all
    task automatic exec_cmd(input string name, input logic [2:0] op, input logic vm,
                            input logic fmt, input logic [1:0] sew, input logic [1:0] lmul,
                            input logic [4:0] vd, input logic [4:0] vs2,
                            input logic [4:0] last, input logic intrude);
        int cyc;
        int n;
        logic seen;
        n = 1 << lmul;
        update_model(op, vm, fmt, sew, lmul, vd, vs2, last);
        @(negedge clk);
        cmd_valid = 1'b1;
        cmd_word  = {op, vm, fmt, sew, lmul, vd, vs2, last};
        @(negedge clk);
        cmd_valid = 1'b0;
        cyc  = 1;
        seen = 1'b0;
        if (busy !== 1'b1 || err !== 1'b0) begin
            $display("%s: legal command did not raise busy or raised err", name);
            errors++;
        end
        if (intrude) begin
            ld_en     = 1'b1;     // Both strobes land while the unit is busy
            ld_addr   = 5'd5;
            ld_data   = ~shadow[5];
            cmd_valid = 1'b1;
            cmd_word  = {3'd0, 1'b1, 1'b0, 2'd0, 2'd0, 5'd6, 5'd7, 5'd7};
            @(negedge clk);
            cyc++;
            ld_en     = 1'b0;
            cmd_valid = 1'b0;
        end
        while (!seen && cyc < 20) begin
            if (done) begin
                seen = 1'b1;
            end
            else begin
                @(negedge clk);
                cyc++;
            end
        end
        if (!seen) begin
            $display("%s: no done pulse arrived after the command", name);
            errors++;
        end
        else if (cyc != n + 2) begin
            $display("ERROR %s done latency: expected %0d, actual %0d", name, n + 2, cyc);
            errors++;
        end
        @(negedge clk);
        if (done !== 1'b0 || busy !== 1'b0) begin
            $display("%s: done or busy still high in the cycle after done", name);
            errors++;
        end
        check_all_regs(name);
    endtask

    task automatic reject_cmd(input string name, input logic [`VEC_CMD_W-1:0] word);
        @(negedge clk);
        cmd_valid = 1'b1;
        cmd_word  = word;
        @(negedge clk);
        cmd_valid = 1'b0;
        if (err !== 1'b1 || busy !== 1'b0) begin
            $display("%s: command was not rejected with an err pulse", name);
            errors++;
        end
        check_all_regs(name);
    endtask

    task automatic begin_test;
        test_start_errors = errors;
        tests++;
    endtask

    task automatic end_test(input string name);
        $display("%s: %0d errors", name, errors - test_start_errors);
    endtask

    task automatic reset_and_loads;
        begin_test();
        check_all_regs("reset_and_loads");
        for (int r = 0; r < 32; r++) begin
            load_reg(5'(r), {$random(seed), $random(seed)});
        end
        check_all_regs("reset_and_loads");
        end_test("reset_and_loads");
    endtask

    task automatic vv_ops_sweep;
        begin_test();
        for (int s = 0; s < 3; s++) begin
            for (int op = 0; op < 8; op++) begin
                exec_cmd("vv_ops_sweep", 3'(op), 1'b1, 1'b0, 2'(s), 2'd0,
                         5'(8 + op), 5'd20, 5'd21, 1'b0);
            end
        end
        end_test("vv_ops_sweep");
    endtask

    task automatic vi_immediates;
        begin_test();
        for (int s = 0; s < 3; s++) begin
            exec_cmd("vi_immediates", 3'd0, 1'b1, 1'b1, 2'(s), 2'd0, 5'd3, 5'd22, 5'h1d, 1'b0);
            exec_cmd("vi_immediates", 3'd0, 1'b1, 1'b1, 2'(s), 2'd0, 5'd4, 5'd23, 5'h0b, 1'b0);
            exec_cmd("vi_immediates", 3'd2, 1'b1, 1'b1, 2'(s), 2'd0, 5'd5, 5'd22, 5'h1b, 1'b0);
        end
        end_test("vi_immediates");
    endtask

    task automatic masked_elements;
        begin_test();
        load_reg(5'd0, {$random(seed), $random(seed)});
        for (int s = 0; s < 3; s++) begin
            exec_cmd("masked_elements", 3'd0, 1'b0, 1'b0, 2'(s), 2'd0, 5'd9, 5'd24, 5'd25, 1'b0);
            exec_cmd("masked_elements", 3'd7, 1'b0, 1'b1, 2'(s), 2'd0, 5'd10, 5'd26, 5'h12,
                     1'b0);
        end
        end_test("masked_elements");
    endtask

    task automatic group_sizes;
        begin_test();
        for (int l = 1; l < 4; l++) begin
            exec_cmd("group_sizes", 3'd1, 1'b1, 1'b0, 2'd1, 2'(l), 5'd8, 5'd16, 5'd24, 1'b0);
            exec_cmd("group_sizes", 3'd5, 1'b0, 1'b0, 2'(l - 1), 2'(l), 5'd8, 5'd16, 5'd24,
                     1'b0);
        end
        end_test("group_sizes");
    endtask

    task automatic illegal_and_dropped;
        begin_test();
        reject_cmd("illegal_and_dropped", {3'd0, 1'b1, 1'b0, 2'd0, 2'd1, 5'd3, 5'd8, 5'd10});
        reject_cmd("illegal_and_dropped", {3'd0, 1'b1, 1'b0, 2'd0, 2'd2, 5'd8, 5'd16, 5'd6});
        reject_cmd("illegal_and_dropped", {3'd0, 1'b1, 1'b0, 2'd3, 2'd0, 5'd8, 5'd16, 5'd24});
        exec_cmd("illegal_and_dropped", 3'd4, 1'b1, 1'b0, 2'd2, 2'd3, 5'd16, 5'd8, 5'd24, 1'b1);
        end_test("illegal_and_dropped");
    endtask

    initial begin
        reset_n    = 1'b0;
        cmd_valid  = 1'b0;
        cmd_word   = '0;
        ld_en      = 1'b0;
        ld_addr    = '0;
        ld_data    = '0;
        rd_addr_in = '0;
        for (int r = 0; r < 32; r++) begin
            shadow[r] = '0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        reset_and_loads();
        vv_ops_sweep();
        vi_immediates();
        masked_elements();
        group_sizes();
        illegal_and_dropped();

        $display("Tests run %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end
        else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+rtl
rtl/vec_pkg.sv
rtl/vec_rf_if.sv
rtl/vec_regbank.sv
rtl/vec_lane_alu.sv
rtl/vec_group_counter.sv
rtl/vec_issue_fsm.sv
rtl/vec_unit.sv
test/tb_vec_unit.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --top-module tb_vec_unit -Mdir obj_dir -f flist.f > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_vec_unit > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "CHECKS FAILED" sim.log; then
    exit 1
fi

if ! grep -q "ALL CHECKS PASSED" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi

exit 0
